// File: logic/udp_tx_pkg.sv
package udp_tx_pkg;

    // datapath geometry
    localparam int DATA_BYTES    = 8;
    localparam int DATA_W        = DATA_BYTES * 8;
    localparam int COUNT_W       = $clog2(DATA_BYTES + 1);

    // fixed header sizes in bytes
    localparam int UDP_HDR_BYTES = 8;
    localparam int IP_HDR_BYTES  = 20;

    // ethernet and ip fields passed through untouched
    typedef struct packed {
        logic [47:0] eth_dest_mac;
        logic [47:0] eth_src_mac;
        logic [15:0] eth_type;
        logic [3:0]  ip_version;
        logic [3:0]  ip_ihl;
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [15:0] ip_identification;
        logic [2:0]  ip_flags;
        logic [12:0] ip_fragment_offset;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_protocol;
        logic [15:0] ip_header_checksum;
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
    } ip_meta_t;

    // output header
    typedef struct packed {
        ip_meta_t    meta;
        logic [15:0] ip_length;
    } ip_hdr_t;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // input header
    typedef struct packed {
        ip_meta_t meta;
        udp_hdr_t udp;
    } udp_frame_hdr_t;

    // one stream beat, valid and ready travel beside it
    typedef struct packed {
        logic [DATA_W-1:0]     data;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
        logic                  user;
    } axis_word_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_HEADER,
        WRITE_PAYLOAD,
        WRITE_PAYLOAD_LAST
    } tx_state_t;

    // number of contiguous set bits from lane 0 up
    function automatic logic [COUNT_W-1:0] keep_to_count(input logic [DATA_BYTES-1:0] keep);
        logic [COUNT_W-1:0] count;
        logic               run;
        count = '0;
        run = 1'b1;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (run && keep[i]) begin
                count = COUNT_W'(i + 1);
            end else begin
                run = 1'b0;
            end
        end
        return count;
    endfunction

    // mask with the low count lanes set
    function automatic logic [DATA_BYTES-1:0] count_to_keep(input logic [COUNT_W-1:0] count);
        logic [DATA_BYTES-1:0] keep;
        for (int i = 0; i < DATA_BYTES; i++) begin
            keep[i] = (i < count);
        end
        return keep;
    endfunction

endpackage

// File: logic/udp_hdr_capture.sv
`timescale 1ns/1ns

module udp_hdr_capture (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_tx_pkg::udp_frame_hdr_t s_hdr,
    input  logic                       hdr_take,
    input  logic                       m_hdr_ready,
    output udp_tx_pkg::udp_hdr_t       udp_fields,
    output udp_tx_pkg::ip_hdr_t        m_hdr,
    output logic                       m_hdr_valid
);

    udp_tx_pkg::ip_hdr_t  hdr_reg;
    udp_tx_pkg::udp_hdr_t udp_reg;
    logic                 valid_reg;

    // header payload registers, loaded once per frame
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            hdr_reg.meta <= s_hdr.meta;
            // ip total length covers the fixed ip header plus the udp datagram
            hdr_reg.ip_length <= s_hdr.udp.length + 16'(udp_tx_pkg::IP_HDR_BYTES);
            udp_reg <= s_hdr.udp;
        end
    end

    // output header handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_reg <= 1'b0;
        end else if (hdr_take) begin
            valid_reg <= 1'b1;
        end else if (m_hdr_ready) begin
            valid_reg <= 1'b0;
        end
    end

    assign m_hdr       = hdr_reg;
    assign m_hdr_valid = valid_reg;
    assign udp_fields  = udp_reg;

endmodule

// File: logic/udp_tx_ctrl.sv
`timescale 1ns/1ns

module udp_tx_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       s_hdr_valid,
    input  udp_tx_pkg::udp_frame_hdr_t s_hdr,
    input  udp_tx_pkg::axis_word_t     s_pay,
    input  logic                       s_pay_valid,
    input  udp_tx_pkg::udp_hdr_t       udp_fields,
    input  logic                       hdr_pending,
    input  logic                       int_ready,
    input  logic                       int_ready_early,
    output logic                       s_hdr_ready,
    output logic                       s_pay_ready,
    output logic                       hdr_take,
    output udp_tx_pkg::axis_word_t     int_word,
    output logic                       int_valid,
    output logic                       busy,
    output logic                       error_early_term
);

    udp_tx_pkg::tx_state_t state, state_next;

    logic [15:0] frame_ptr, frame_ptr_next;
    logic [16:0] ptr_sum;
    logic [15:0] remain;
    logic        pay_xfer;

    logic s_hdr_ready_next;
    logic s_pay_ready_next;
    logic error_next;
    logic store_last;

    logic [udp_tx_pkg::DATA_W-1:0]     last_data;
    logic [udp_tx_pkg::DATA_BYTES-1:0] last_keep;

    // udp header as it goes on the wire, each field msb first
    function automatic logic [udp_tx_pkg::DATA_W-1:0] udp_hdr_word(
        input udp_tx_pkg::udp_hdr_t h
    );
        return {h.checksum[7:0], h.checksum[15:8],
                h.length[7:0], h.length[15:8],
                h.dest_port[7:0], h.dest_port[15:8],
                h.src_port[7:0], h.src_port[15:8]};
    endfunction

    assign pay_xfer = s_pay_valid && s_pay_ready;
    assign ptr_sum  = {1'b0, frame_ptr} + 17'(udp_tx_pkg::keep_to_count(s_pay.keep));
    // bytes still owed, at most one word once ptr_sum reaches the length
    assign remain   = udp_fields.length - frame_ptr;

    always_comb begin
        state_next       = state;
        frame_ptr_next   = frame_ptr;
        s_hdr_ready_next = 1'b0;
        s_pay_ready_next = 1'b0;
        hdr_take         = 1'b0;
        store_last       = 1'b0;
        error_next       = 1'b0;
        int_word         = '0;
        int_valid        = 1'b0;

        case (state)
            udp_tx_pkg::IDLE: begin
                frame_ptr_next   = '0;
                s_hdr_ready_next = !hdr_pending;
                if (s_hdr_ready && s_hdr_valid) begin
                    hdr_take         = 1'b1;
                    s_hdr_ready_next = 1'b0;
                    state_next       = udp_tx_pkg::WRITE_HEADER;
                    // skip a cycle by sending straight from the live header
                    if (int_ready) begin
                        int_word.data    = udp_hdr_word(s_hdr.udp);
                        int_word.keep    = '1;
                        int_valid        = 1'b1;
                        frame_ptr_next   = 16'(udp_tx_pkg::UDP_HDR_BYTES);
                        s_pay_ready_next = int_ready_early;
                        state_next       = udp_tx_pkg::WRITE_PAYLOAD;
                    end
                end
            end

            udp_tx_pkg::WRITE_HEADER: begin
                if (int_ready) begin
                    int_word.data    = udp_hdr_word(udp_fields);
                    int_word.keep    = '1;
                    int_valid        = 1'b1;
                    frame_ptr_next   = 16'(udp_tx_pkg::UDP_HDR_BYTES);
                    s_pay_ready_next = int_ready_early;
                    state_next       = udp_tx_pkg::WRITE_PAYLOAD;
                end
            end

            udp_tx_pkg::WRITE_PAYLOAD: begin
                s_pay_ready_next = int_ready_early;
                int_word         = s_pay;
                int_valid        = pay_xfer;
                if (pay_xfer) begin
                    frame_ptr_next = ptr_sum[15:0];
                    if (ptr_sum >= {1'b0, udp_fields.length}) begin
                        // length reached, trim this word
                        frame_ptr_next = udp_fields.length;
                        int_word.keep  = udp_tx_pkg::count_to_keep(
                            remain[udp_tx_pkg::COUNT_W-1:0]);
                        if (s_pay.last) begin
                            s_pay_ready_next = 1'b0;
                            s_hdr_ready_next = !hdr_pending;
                            state_next       = udp_tx_pkg::IDLE;
                        end else begin
                            // hold it back until the input frame ends
                            store_last = 1'b1;
                            int_valid  = 1'b0;
                            state_next = udp_tx_pkg::WRITE_PAYLOAD_LAST;
                        end
                    end else if (s_pay.last) begin
                        // input ended short of the udp length
                        int_word.user    = 1'b1;
                        error_next       = 1'b1;
                        s_pay_ready_next = 1'b0;
                        s_hdr_ready_next = !hdr_pending;
                        state_next       = udp_tx_pkg::IDLE;
                    end
                end
            end

            udp_tx_pkg::WRITE_PAYLOAD_LAST: begin
                // drop surplus words, release the held one on last
                s_pay_ready_next = int_ready_early;
                int_word.data    = last_data;
                int_word.keep    = last_keep;
                int_word.last    = s_pay.last;
                int_word.user    = s_pay.user;
                int_valid        = pay_xfer && s_pay.last;
                if (pay_xfer && s_pay.last) begin
                    s_pay_ready_next = 1'b0;
                    s_hdr_ready_next = !hdr_pending;
                    state_next       = udp_tx_pkg::IDLE;
                end
            end

            default: begin
                state_next = udp_tx_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= udp_tx_pkg::IDLE;
            frame_ptr        <= '0;
            s_hdr_ready      <= 1'b0;
            s_pay_ready      <= 1'b0;
            busy             <= 1'b0;
            error_early_term <= 1'b0;
        end else begin
            state            <= state_next;
            frame_ptr        <= frame_ptr_next;
            s_hdr_ready      <= s_hdr_ready_next;
            s_pay_ready      <= s_pay_ready_next;
            busy             <= (state_next != udp_tx_pkg::IDLE);
            error_early_term <= error_next;
        end
    end

    // trimmed final word parked while the tail is discarded
    always_ff @(posedge clk) begin
        if (store_last) begin
            last_data <= int_word.data;
            last_keep <= int_word.keep;
        end
    end

endmodule

// File: logic/axis_skid_out.sv
`timescale 1ns/1ns

module axis_skid_out (
    input  logic                   clk,
    input  logic                   rst,
    input  udp_tx_pkg::axis_word_t int_word,
    input  logic                   int_valid,
    input  logic                   m_pay_ready,
    output logic                   int_ready,
    output logic                   int_ready_early,
    output udp_tx_pkg::axis_word_t m_pay,
    output logic                   m_pay_valid
);

    udp_tx_pkg::axis_word_t out_word;
    udp_tx_pkg::axis_word_t temp_word;
    logic                   out_valid, out_valid_next;
    logic                   temp_valid, temp_valid_next;

    logic int_to_out;
    logic int_to_temp;
    logic temp_to_out;

    // ready next cycle unless temp could end up holding a word
    assign int_ready_early = m_pay_ready || (!temp_valid && (!out_valid || !int_valid));

    always_comb begin
        out_valid_next  = out_valid;
        temp_valid_next = temp_valid;
        int_to_out      = 1'b0;
        int_to_temp     = 1'b0;
        temp_to_out     = 1'b0;

        if (int_ready) begin
            if (m_pay_ready || !out_valid) begin
                out_valid_next = int_valid;
                int_to_out     = 1'b1;
            end else begin
                // output stalled, park in temp
                temp_valid_next = int_valid;
                int_to_temp     = 1'b1;
            end
        end else if (m_pay_ready) begin
            // drain temp into the output
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            int_ready  <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            int_ready  <= int_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            out_word <= int_word;
        end else if (temp_to_out) begin
            out_word <= temp_word;
        end
        if (int_to_temp) begin
            temp_word <= int_word;
        end
    end

    assign m_pay       = out_word;
    assign m_pay_valid = out_valid;

endmodule

// File: logic/udp_ip_tx.sv
`timescale 1ns/1ns

module udp_ip_tx (
    input  logic                       clk,
    input  logic                       rst,

    // udp frame in
    input  udp_tx_pkg::udp_frame_hdr_t s_hdr,
    input  logic                       s_hdr_valid,
    output logic                       s_hdr_ready,
    input  udp_tx_pkg::axis_word_t     s_pay,
    input  logic                       s_pay_valid,
    output logic                       s_pay_ready,

    // ip frame out
    output udp_tx_pkg::ip_hdr_t        m_hdr,
    output logic                       m_hdr_valid,
    input  logic                       m_hdr_ready,
    output udp_tx_pkg::axis_word_t     m_pay,
    output logic                       m_pay_valid,
    input  logic                       m_pay_ready,

    // status
    output logic                       busy,
    output logic                       error_early_term
);

    logic                   hdr_take;
    udp_tx_pkg::udp_hdr_t   udp_fields;
    udp_tx_pkg::axis_word_t int_word;
    logic                   int_valid;
    logic                   int_ready;
    logic                   int_ready_early;

    udp_hdr_capture u_hdr (
        .clk         (clk),
        .rst         (rst),
        .s_hdr       (s_hdr),
        .hdr_take    (hdr_take),
        .m_hdr_ready (m_hdr_ready),
        .udp_fields  (udp_fields),
        .m_hdr       (m_hdr),
        .m_hdr_valid (m_hdr_valid)
    );

    udp_tx_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .s_hdr_valid      (s_hdr_valid),
        .s_hdr            (s_hdr),
        .s_pay            (s_pay),
        .s_pay_valid      (s_pay_valid),
        .udp_fields       (udp_fields),
        .hdr_pending      (m_hdr_valid),
        .int_ready        (int_ready),
        .int_ready_early  (int_ready_early),
        .s_hdr_ready      (s_hdr_ready),
        .s_pay_ready      (s_pay_ready),
        .hdr_take         (hdr_take),
        .int_word         (int_word),
        .int_valid        (int_valid),
        .busy             (busy),
        .error_early_term (error_early_term)
    );

    axis_skid_out u_skid (
        .clk             (clk),
        .rst             (rst),
        .int_word        (int_word),
        .int_valid       (int_valid),
        .m_pay_ready     (m_pay_ready),
        .int_ready       (int_ready),
        .int_ready_early (int_ready_early),
        .m_pay           (m_pay),
        .m_pay_valid     (m_pay_valid)
    );

endmodule

// File: bench/udp_ip_tx_properties.sv
`timescale 1ns/1ns

module udp_ip_tx_properties (
    input logic                   clk,
    input logic                   rst,
    input udp_tx_pkg::axis_word_t m_pay,
    input logic                   m_pay_valid,
    input logic                   m_pay_ready,
    input udp_tx_pkg::ip_hdr_t    m_hdr,
    input logic                   m_hdr_valid,
    input logic                   m_hdr_ready,
    input logic                   s_hdr_ready,
    input logic                   s_pay_ready,
    input logic                   busy,
    input logic                   error_early_term
);

    int fail_count = 0;

    // stalled payload word stays put
    assert property (@(posedge clk) disable iff (rst)
        m_pay_valid && !m_pay_ready |=> m_pay_valid && $stable(m_pay))
    else begin
        $error("m_pay changed or dropped while stalled");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_hdr))
    else begin
        $error("m_hdr changed or dropped before m_hdr_ready");
        fail_count++;
    end

    assert property (@(posedge clk)
        rst |=> !s_hdr_ready && !s_pay_ready && !m_hdr_valid && !m_pay_valid
                && !busy && !error_early_term)
    else begin
        $error("outputs not low after reset");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        error_early_term |=> !error_early_term)
    else begin
        $error("error_early_term held for two cycles");
        fail_count++;
    end

endmodule

bind udp_ip_tx udp_ip_tx_properties props (
    .clk              (clk),
    .rst              (rst),
    .m_pay            (m_pay),
    .m_pay_valid      (m_pay_valid),
    .m_pay_ready      (m_pay_ready),
    .m_hdr            (m_hdr),
    .m_hdr_valid      (m_hdr_valid),
    .m_hdr_ready      (m_hdr_ready),
    .s_hdr_ready      (s_hdr_ready),
    .s_pay_ready      (s_pay_ready),
    .busy             (busy),
    .error_early_term (error_early_term)
);

// File: bench/udp_ip_tx_tb.sv
`timescale 1ns/1ns

module udp_ip_tx_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 2000;

    logic                       clk;
    logic                       rst;
    udp_tx_pkg::udp_frame_hdr_t s_hdr;
    logic                       s_hdr_valid;
    logic                       s_hdr_ready;
    udp_tx_pkg::axis_word_t     s_pay;
    logic                       s_pay_valid;
    logic                       s_pay_ready;
    udp_tx_pkg::ip_hdr_t        m_hdr;
    logic                       m_hdr_valid;
    logic                       m_hdr_ready;
    udp_tx_pkg::axis_word_t     m_pay;
    logic                       m_pay_valid;
    logic                       m_pay_ready;
    logic                       busy;
    logic                       error_early_term;

    // filled by the monitor only
    udp_tx_pkg::axis_word_t got_words[$];
    udp_tx_pkg::ip_hdr_t    got_hdrs[$];
    int                     err_pulses = 0;
    int                     busy_gaps = 0;

    udp_tx_pkg::axis_word_t in_words[$];
    udp_tx_pkg::axis_word_t exp_words[$];
    udp_tx_pkg::ip_hdr_t    exp_hdrs[$];
    logic                   exp_err;
    logic                   stall_on = 1'b0;
    int                     seed = 16;
    int                     errors = 0;
    int                     test_errors;
    int                     tests_run = 0;
    int                     word_base;
    int                     hdr_base;
    int                     pulse_base;
    int                     gap_base;

    udp_ip_tx DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // random sink ready while stalls are on
    initial begin
        int r;
        m_pay_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (stall_on) begin
                r = $random(seed);
                m_pay_ready = r[0];
            end else begin
                m_pay_ready = 1'b1;
            end
        end
    end

    // outputs sampled mid cycle ahead of the transfer edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (m_pay_valid && m_pay_ready) got_words.push_back(m_pay);
                if (m_hdr_valid && m_hdr_ready) got_hdrs.push_back(m_hdr);
                if (error_early_term) err_pulses++;
                if (s_pay_valid && s_pay_ready && !busy) busy_gaps++;
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (5 + NUM_TESTS * CYCLES_PER_TEST));
        $display("timeout: the frames did not complete within %0d cycles per test",
                 CYCLES_PER_TEST);
        $display("Done: errors found");
        $finish;
    end

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic compare_word(input string name, input udp_tx_pkg::axis_word_t got,
                                input udp_tx_pkg::axis_word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_hdr(input string name, input udp_tx_pkg::ip_hdr_t got,
                               input udp_tx_pkg::ip_hdr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    function automatic udp_tx_pkg::udp_frame_hdr_t make_hdr(input int tag, input int udp_len);
        udp_tx_pkg::udp_frame_hdr_t h;
        h.meta.eth_dest_mac       = {16'h0200, 32'(tag)};
        h.meta.eth_src_mac        = {16'h0a00, 32'(tag * 3)};
        h.meta.eth_type           = 16'h0800;
        h.meta.ip_version         = 4'd4;
        h.meta.ip_ihl             = 4'd5;
        h.meta.ip_dscp            = 6'(tag);
        h.meta.ip_ecn             = 2'(tag);
        h.meta.ip_identification  = 16'(tag * 17);
        h.meta.ip_flags           = 3'b010;
        h.meta.ip_fragment_offset = 13'(tag);
        h.meta.ip_ttl             = 8'd64;
        h.meta.ip_protocol        = 8'd17;
        h.meta.ip_header_checksum = 16'(tag * 257);
        h.meta.ip_source_ip       = {8'd10, 8'd0, 8'd0, 8'(tag)};
        h.meta.ip_dest_ip         = {8'd192, 8'd168, 8'd1, 8'(tag)};
        h.udp.src_port            = 16'(4096 + tag);
        h.udp.dest_port           = 16'(8192 + tag * 2);
        h.udp.length              = 16'(udp_len);
        h.udp.checksum            = 16'(tag * 4099);
        return h;
    endfunction

    task automatic load_payload(input int tag, input int nwords, input logic [7:0] last_keep,
                                input logic last_user);
        udp_tx_pkg::axis_word_t w;
        in_words.delete();
        for (int i = 0; i < nwords; i++) begin
            w.data = {32'(tag), 32'(i) ^ 32'hc0de_0000};
            w.last = (i == nwords - 1);
            w.keep = w.last ? last_keep : 8'hff;
            w.user = w.last ? last_user : 1'b0;
            in_words.push_back(w);
        end
    endtask

    // expected output for one frame built from in_words
    task automatic add_expected(input udp_tx_pkg::udp_frame_hdr_t h);
        udp_tx_pkg::axis_word_t w;
        udp_tx_pkg::ip_hdr_t    eh;
        logic [7:0]             b [8];
        int                     remaining;
        int                     n;
        logic                   done;
        eh.meta      = h.meta;
        eh.ip_length = 16'(int'(h.udp.length) + 20);
        exp_hdrs.push_back(eh);
        // lane 0 leads with each field high byte first
        b[0] = h.udp.src_port[15:8];
        b[1] = h.udp.src_port[7:0];
        b[2] = h.udp.dest_port[15:8];
        b[3] = h.udp.dest_port[7:0];
        b[4] = h.udp.length[15:8];
        b[5] = h.udp.length[7:0];
        b[6] = h.udp.checksum[15:8];
        b[7] = h.udp.checksum[7:0];
        w = '0;
        for (int i = 0; i < 8; i++) w.data[i*8 +: 8] = b[i];
        w.keep = 8'hff;
        exp_words.push_back(w);
        remaining = int'(h.udp.length) - udp_tx_pkg::UDP_HDR_BYTES;
        done = 1'b0;
        foreach (in_words[i]) begin
            if (!done) begin
                w = in_words[i];
                n = 0;
                while (n < 8 && w.keep[n]) n++;
                if (n >= remaining) begin
                    w.keep = 8'((1 << remaining) - 1);
                    w.last = 1'b1;
                    w.user = in_words[in_words.size() - 1].user;
                    done = 1'b1;
                end else if (w.last) begin
                    w.user = 1'b1;
                    exp_err = 1'b1;
                    done = 1'b1;
                end
                remaining -= n;
                exp_words.push_back(w);
            end
        end
    endtask

    task automatic send_header(input udp_tx_pkg::udp_frame_hdr_t h);
        s_hdr = h;
        s_hdr_valid = 1'b1;
        @(negedge clk);
        while (!s_hdr_ready) @(negedge clk);
        @(posedge clk);
        #1;
        s_hdr_valid = 1'b0;
    endtask

    task automatic send_payload();
        foreach (in_words[i]) begin
            s_pay = in_words[i];
            s_pay_valid = 1'b1;
            @(negedge clk);
            while (!s_pay_ready) @(negedge clk);
            @(posedge clk);
            #1;
        end
        s_pay_valid = 1'b0;
    endtask

    task automatic set_stalls(input logic on);
        @(negedge clk);
        stall_on = on;
        @(posedge clk);
        #1;
    endtask

    task automatic start_test();
        word_base  = got_words.size();
        hdr_base   = got_hdrs.size();
        pulse_base = err_pulses;
        gap_base   = busy_gaps;
        exp_words.delete();
        exp_hdrs.delete();
        exp_err     = 1'b0;
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        int n_words;
        int n_hdrs;
        int pulses;
        while (got_words.size() < word_base + exp_words.size() ||
               got_hdrs.size() < hdr_base + exp_hdrs.size()) begin
            @(negedge clk);
        end
        // idle cycles to catch surplus output
        repeat (4) @(negedge clk);
        n_words = got_words.size() - word_base;
        n_hdrs  = got_hdrs.size() - hdr_base;
        pulses  = err_pulses - pulse_base;
        if (n_words != exp_words.size())
            report_failure($sformatf("%0d output words, expected %0d", n_words,
                                     exp_words.size()));
        foreach (exp_words[i]) begin
            if (i < n_words) compare_word("m_pay", got_words[word_base + i], exp_words[i]);
        end
        if (n_hdrs != exp_hdrs.size())
            report_failure($sformatf("%0d output headers, expected %0d", n_hdrs,
                                     exp_hdrs.size()));
        foreach (exp_hdrs[i]) begin
            if (i < n_hdrs) compare_hdr("m_hdr", got_hdrs[hdr_base + i], exp_hdrs[i]);
        end
        compare_bit("error_early_term", pulses != 0, exp_err);
        if (pulses > 1) report_failure("error_early_term pulsed more than once");
        if (busy_gaps != gap_base) report_failure("busy was low while payload was accepted");
        tests_run++;
        $display("test %s finished with %0d errors", name, test_errors);
        @(posedge clk);
        #1;
    endtask

    task automatic exact_length_frame();
        udp_tx_pkg::udp_frame_hdr_t h;
        start_test();
        h = make_hdr(1, 28);
        load_payload(1, 3, 8'h0f, 1'b0);
        add_expected(h);
        send_header(h);
        send_payload();
        finish_test("exact length");
    endtask

    // 13 payload bytes against four input words
    task automatic long_frame_trim();
        udp_tx_pkg::udp_frame_hdr_t h;
        start_test();
        h = make_hdr(2, 21);
        load_payload(2, 4, 8'hff, 1'b1);
        add_expected(h);
        send_header(h);
        send_payload();
        finish_test("long frame");
    endtask

    task automatic short_frame_error();
        udp_tx_pkg::udp_frame_hdr_t h;
        start_test();
        h = make_hdr(3, 32);
        load_payload(3, 2, 8'hff, 1'b0);
        add_expected(h);
        send_header(h);
        send_payload();
        finish_test("short frame");
    endtask

    task automatic random_output_stalls();
        udp_tx_pkg::udp_frame_hdr_t h;
        start_test();
        h = make_hdr(4, 59);
        load_payload(4, 7, 8'h07, 1'b0);
        add_expected(h);
        set_stalls(1'b1);
        send_header(h);
        send_payload();
        finish_test("output stalls");
        set_stalls(1'b0);
    endtask

    task automatic held_header_blocks();
        udp_tx_pkg::udp_frame_hdr_t ha;
        udp_tx_pkg::udp_frame_hdr_t hb;
        logic                       ready_seen;
        start_test();
        ha = make_hdr(5, 36);
        hb = make_hdr(6, 22);
        load_payload(5, 4, 8'h0f, 1'b0);
        add_expected(ha);
        m_hdr_ready = 1'b0;
        send_header(ha);
        send_payload();
        @(negedge clk);
        compare_bit("busy", busy, 1'b0);
        compare_bit("m_hdr_valid", m_hdr_valid, 1'b1);
        @(posedge clk);
        #1;
        // second header must wait for the first one to leave
        s_hdr = hb;
        s_hdr_valid = 1'b1;
        ready_seen = 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (s_hdr_ready) ready_seen = 1'b1;
        end
        compare_bit("s_hdr_ready", ready_seen, 1'b0);
        @(posedge clk);
        #1;
        m_hdr_ready = 1'b1;
        send_header(hb);
        load_payload(6, 2, 8'h3f, 1'b0);
        add_expected(hb);
        send_payload();
        finish_test("output header held");
    endtask

    initial begin
        int total;
        rst         = 1'b1;
        s_hdr       = '0;
        s_hdr_valid = 1'b0;
        s_pay       = '0;
        s_pay_valid = 1'b0;
        m_hdr_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        exact_length_frame();
        long_frame_trim();
        short_frame_error();
        random_output_stalls();
        held_header_blocks();
        total = errors + DUT.props.fail_count;
        $display("tests run %0d, check errors %0d, assertion failures %0d",
                 tests_run, errors, DUT.props.fail_count);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/udp_tx_pkg.sv
logic/udp_hdr_capture.sv
logic/udp_tx_ctrl.sv
logic/axis_skid_out.sv
logic/udp_ip_tx.sv
bench/udp_ip_tx_properties.sv
bench/udp_ip_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the udp transmitter testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module udp_ip_tx_tb \
    -o udp_ip_tx_sim -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/udp_ip_tx_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation passed"
exit 0
